/* design/ps2_pkg.sv */
// receive-only PS/2 definitions; scan codes assume keyboard scan code set 2
`default_nettype none

package ps2_pkg;

  // ----------------------------------------------------------------------
  // frame format
  // ----------------------------------------------------------------------

  // start bit + 8 data bits (lsb first) + odd parity + stop bit
  localparam int frame_bits = 11;

  // ----------------------------------------------------------------------
  // byte types
  // ----------------------------------------------------------------------

  typedef logic [7:0] code_t;   // raw scan code byte from the keyboard
  typedef logic [7:0] ascii_t;  // translated character, 00 when unmapped

  // ----------------------------------------------------------------------
  // prefix codes
  // ----------------------------------------------------------------------

  // a prefix is held until the next non-prefix code arrives
  localparam code_t extend_code  = 8'hE0;  // extended key follows
  localparam code_t release_code = 8'hF0;  // key release follows

  // ----------------------------------------------------------------------
  // modifier keys
  // ----------------------------------------------------------------------

  // left and right shift share one level at the host side
  localparam code_t left_shift_code   = 8'h12;
  localparam code_t right_shift_code  = 8'h59;

  // right control arrives as E0 14 and is tracked the same way
  localparam code_t left_control_code = 8'h14;

endpackage

`default_nettype wire

/* design/key_event_if.sv */
// one decoded key event per strobe pulse; the sink has no way to stall the source
`timescale 1ns/100ps
`default_nettype none

interface key_event_if;

  logic              strobe;      // one clk wide, fields valid only here
  ps2_pkg::code_t    scan_code;   // code of the key itself, prefixes stripped
  logic              extended;    // an E0 came before this code
  logic              released;    // an F0 came before this code
  logic              shift_on;    // level of either shift key
  logic              control_on;  // level of left control

  // code tracker drives the event
  modport source (
    output strobe, scan_code, extended, released, shift_on, control_on
  );

  // output stage samples on strobe, reads the levels at any time
  modport sink (
    input strobe, scan_code, extended, released, shift_on, control_on
  );

endinterface

`default_nettype wire

/* design/ps2_frame_receiver.sv */
// keyboard clock half period must stay well above 2 clk cycles and below watchdog_cycles
`timescale 1ns/100ps
`default_nettype none

module ps2_frame_receiver #(
  parameter int watchdog_cycles = 3096  // idle clk cycles before a partial frame is dropped
) (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire logic           ps2_clk,     // keyboard clock, asynchronous
  input  wire logic           ps2_data,    // keyboard data, asynchronous
  output      logic           frame_done,  // one clk pulse per complete frame
  output      ps2_pkg::code_t scan_code    // valid with frame_done
);

  localparam int count_w = $clog2(ps2_pkg::frame_bits + 1);
  localparam int timer_w = $clog2(watchdog_cycles + 1);

  // line follower states
  localparam logic [1:0] st_clk_high = 2'd0;
  localparam logic [1:0] st_fall     = 2'd1;  // one cycle after clock went low
  localparam logic [1:0] st_clk_low  = 2'd2;
  localparam logic [1:0] st_rise     = 2'd3;  // one cycle after clock went high

  logic [1:0]                    clk_sync;   // [1] is the usable copy
  logic [1:0]                    data_sync;
  logic [1:0]                    state;
  logic [1:0]                    next_state;
  logic [count_w-1:0]            bit_count;
  logic [ps2_pkg::frame_bits-1:0] shift_q;   // stop bit ends up at the top
  logic [timer_w-1:0]            timer_count;
  logic                          timer_run;
  logic                          timer_done;

  // ----------------------------------------------------------------------
  // input synchroniser
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_sync  <= 2'b11;  // idle lines are pulled high
      data_sync <= 2'b11;
    end
    else
    begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
    end
  end

  // ----------------------------------------------------------------------
  // keyboard clock follower
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_clk_high;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      st_clk_high : if (!clk_sync[1]) next_state = st_fall;
      st_fall     : next_state = st_clk_low;   // marker lasts exactly one cycle
      st_clk_low  : if (clk_sync[1]) next_state = st_rise;
      st_rise     : next_state = st_clk_high;
      default     : next_state = st_clk_high;
    endcase
  end

  // ----------------------------------------------------------------------
  // shift register and bit counter
  // ----------------------------------------------------------------------

  // data is stable while the keyboard clock is low, so sample at the fall marker
  always_ff @(posedge clk)
  begin
    if (state == st_fall)
      shift_q <= {data_sync[1], shift_q[ps2_pkg::frame_bits-1:1]};  // lsb arrives first
  end

  always_ff @(posedge clk)
  begin
    if (reset || frame_done)
      bit_count <= '0;
    else if (timer_done && (state == st_clk_high) && clk_sync[1])
      bit_count <= '0;                       // watchdog drops a partial frame
    else if (state == st_fall)
      bit_count <= bit_count + 1'b1;
  end

  assign frame_done = (bit_count == count_w'(ps2_pkg::frame_bits));
  assign scan_code  = shift_q[8:1];  // skip the start bit, drop parity and stop

  // ----------------------------------------------------------------------
  // idle watchdog
  // ----------------------------------------------------------------------

  assign timer_run  = (state == st_clk_high) || (state == st_clk_low);
  assign timer_done = (timer_count == timer_w'(watchdog_cycles - 1));

  always_ff @(posedge clk)
  begin
    if (reset || !timer_run)
      timer_count <= '0;                     // restarts at every clock edge marker
    else if (!timer_done)
      timer_count <= timer_count + 1'b1;     // holds at the limit
  end

endmodule

`default_nettype wire

/* design/ps2_code_tracker.sv */
// modifier levels follow press/release codes only; right control (E0 14) counts as left
`timescale 1ns/100ps
`default_nettype none

module ps2_code_tracker #(
  parameter bit trap_modifiers = 1'b1  // 1: shift and control codes give no event
) (
  input  wire logic           clk,
  input  wire logic           reset,
  input  wire logic           frame_done,  // one pulse per received byte
  input  wire ps2_pkg::code_t scan_code,   // valid with frame_done
  key_event_if.source         ev
);

  logic is_extend;        // current byte is E0
  logic is_release;       // current byte is F0
  logic is_left_shift;
  logic is_right_shift;
  logic is_left_control;
  logic is_modifier;
  logic key_code;         // complete key code, prefixes already seen
  logic hold_extended;    // E0 seen since the last key code
  logic hold_released;    // F0 seen since the last key code
  logic left_shift;
  logic right_shift;
  logic left_control;

  // ----------------------------------------------------------------------
  // code classification
  // ----------------------------------------------------------------------

  assign is_extend       = (scan_code == ps2_pkg::extend_code);
  assign is_release      = (scan_code == ps2_pkg::release_code);
  assign is_left_shift   = (scan_code == ps2_pkg::left_shift_code);
  assign is_right_shift  = (scan_code == ps2_pkg::right_shift_code);
  assign is_left_control = (scan_code == ps2_pkg::left_control_code);
  assign is_modifier     = is_left_shift || is_right_shift || is_left_control;

  assign key_code = frame_done && !is_extend && !is_release;

  // ----------------------------------------------------------------------
  // prefix holding
  // ----------------------------------------------------------------------

  // a trapped modifier still consumes the prefixes ahead of it
  always_ff @(posedge clk)
  begin
    if (reset || key_code)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (frame_done)
    begin
      if (is_extend)  hold_extended <= 1'b1;
      if (is_release) hold_released <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // modifier levels
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift   <= 1'b0;
      right_shift  <= 1'b0;
      left_control <= 1'b0;
    end
    else if (key_code)
    begin
      if (is_left_shift)   left_shift   <= !hold_released;  // F0 prefix means key up
      if (is_right_shift)  right_shift  <= !hold_released;
      if (is_left_control) left_control <= !hold_released;
    end
  end

  // ----------------------------------------------------------------------
  // event out
  // ----------------------------------------------------------------------

  // same cycle as frame_done, flags and levels are the ones held before this code
  assign ev.strobe     = key_code && !(trap_modifiers && is_modifier);
  assign ev.scan_code  = scan_code;
  assign ev.extended   = hold_extended;
  assign ev.released   = hold_released;
  assign ev.shift_on   = left_shift || right_shift;
  assign ev.control_on = left_control;

endmodule

`default_nettype wire

/* design/scan_ascii_map.sv */
// partial set 2 table: letters, digits, shifted digits, control letters, a few edit keys
`timescale 1ns/100ps
`default_nettype none

module scan_ascii_map (
  input  wire ps2_pkg::code_t  scan_code,
  input  wire logic            extended,    // E0 prefix held for this code
  input  wire logic            shift_on,
  input  wire logic            control_on,
  output      ps2_pkg::ascii_t ascii        // 00 for anything not in the table
);

  logic [4:0]      letter_idx;   // 1 for a .. 26 for z, 0 when not a letter
  logic [3:0]      digit_val;
  logic            is_digit;
  logic            is_edit;
  ps2_pkg::ascii_t edit_ascii;
  ps2_pkg::ascii_t shift_digit;  // symbol above the digit key

  // ----------------------------------------------------------------------
  // key lookups
  // ----------------------------------------------------------------------

  always_comb
  begin
    letter_idx = 5'd0;
    case (scan_code)
      8'h1C : letter_idx = 5'd1;   // a
      8'h32 : letter_idx = 5'd2;   // b
      8'h21 : letter_idx = 5'd3;
      8'h23 : letter_idx = 5'd4;
      8'h24 : letter_idx = 5'd5;   // e
      8'h2B : letter_idx = 5'd6;
      8'h34 : letter_idx = 5'd7;
      8'h33 : letter_idx = 5'd8;
      8'h43 : letter_idx = 5'd9;   // i
      8'h3B : letter_idx = 5'd10;
      8'h42 : letter_idx = 5'd11;
      8'h4B : letter_idx = 5'd12;
      8'h3A : letter_idx = 5'd13;  // m
      8'h31 : letter_idx = 5'd14;
      8'h44 : letter_idx = 5'd15;
      8'h4D : letter_idx = 5'd16;
      8'h15 : letter_idx = 5'd17;  // q
      8'h2D : letter_idx = 5'd18;
      8'h1B : letter_idx = 5'd19;
      8'h2C : letter_idx = 5'd20;
      8'h3C : letter_idx = 5'd21;  // u
      8'h2A : letter_idx = 5'd22;
      8'h1D : letter_idx = 5'd23;
      8'h22 : letter_idx = 5'd24;
      8'h35 : letter_idx = 5'd25;
      8'h1A : letter_idx = 5'd26;  // z
      default : letter_idx = 5'd0;
    endcase
  end

  // digit row, with the shifted symbol of each key
  always_comb
  begin
    is_digit    = 1'b1;
    digit_val   = 4'd0;
    shift_digit = 8'h00;
    case (scan_code)
      8'h45 : begin digit_val = 4'd0; shift_digit = 8'h29; end  // )
      8'h16 : begin digit_val = 4'd1; shift_digit = 8'h21; end  // !
      8'h1E : begin digit_val = 4'd2; shift_digit = 8'h40; end  // @
      8'h26 : begin digit_val = 4'd3; shift_digit = 8'h23; end  // #
      8'h25 : begin digit_val = 4'd4; shift_digit = 8'h24; end  // $
      8'h2E : begin digit_val = 4'd5; shift_digit = 8'h25; end  // %
      8'h36 : begin digit_val = 4'd6; shift_digit = 8'h5E; end  // ^
      8'h3D : begin digit_val = 4'd7; shift_digit = 8'h26; end  // &
      8'h3E : begin digit_val = 4'd8; shift_digit = 8'h2A; end  // *
      8'h46 : begin digit_val = 4'd9; shift_digit = 8'h28; end  // (
      default : is_digit = 1'b0;
    endcase
  end

  // edit keys ignore shift and control
  always_comb
  begin
    is_edit    = 1'b1;
    edit_ascii = 8'h00;
    case (scan_code)
      8'h29 : edit_ascii = 8'h20;  // space
      8'h5A : edit_ascii = 8'h0D;  // enter
      8'h66 : edit_ascii = 8'h08;  // backspace
      8'h0D : edit_ascii = 8'h09;  // tab
      8'h76 : edit_ascii = 8'h1B;  // escape
      default : is_edit = 1'b0;
    endcase
  end

  // ----------------------------------------------------------------------
  // priority select
  // ----------------------------------------------------------------------

  always_comb
  begin
    if (extended)
      ascii = (scan_code == 8'h5A) ? 8'h0D :            // keypad enter
              (scan_code == 8'h71) ? 8'h7F : 8'h00;     // delete
    else if (is_edit)
      ascii = edit_ascii;
    else if (control_on && (letter_idx != 5'd0))
      ascii = {3'b000, letter_idx};                     // ^a = 01 .. ^z = 1A
    else if (shift_on && (letter_idx != 5'd0))
      ascii = 8'h40 + {3'b000, letter_idx};             // upper case
    else if (shift_on && is_digit)
      ascii = shift_digit;
    else if (letter_idx != 5'd0)
      ascii = 8'h60 + {3'b000, letter_idx};             // lower case
    else if (is_digit)
      ascii = 8'h30 + {4'h0, digit_val};
    else
      ascii = 8'h00;
  end

endmodule

`default_nettype wire

/* design/ps2_rx_output.sv */
// single event holding stage; a new event overwrites an unread one without warning
`timescale 1ns/100ps
`default_nettype none

module ps2_rx_output (
  input  wire logic            clk,
  input  wire logic            reset,
  key_event_if.sink            ev,
  input  wire logic            rx_read,        // host has taken the event
  output      ps2_pkg::code_t  rx_scan_code,
  output      ps2_pkg::ascii_t rx_ascii,
  output      logic            rx_extended,
  output      logic            rx_released,
  output      logic            rx_data_ready   // level, cleared by rx_read
);

  localparam logic st_idle  = 1'b0;
  localparam logic st_ready = 1'b1;

  ps2_pkg::ascii_t ascii;
  logic            state;
  logic            next_state;

  // translation uses the modifier levels as they stood before this code
  scan_ascii_map map0 (
    .scan_code  (ev.scan_code),
    .extended   (ev.extended),
    .shift_on   (ev.shift_on),
    .control_on (ev.control_on),
    .ascii      (ascii)
  );

  // ----------------------------------------------------------------------
  // output registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_scan_code <= '0;
      rx_ascii     <= '0;
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
    end
    else if (ev.strobe)
    begin
      rx_scan_code <= ev.scan_code;
      rx_ascii     <= ascii;
      rx_extended  <= ev.extended;
      rx_released  <= ev.released;
    end
  end

  // ----------------------------------------------------------------------
  // ready/read handshake
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= st_idle;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      st_idle  : if (ev.strobe) next_state = st_ready;
      st_ready : if (!ev.strobe && rx_read) next_state = st_idle;  // new event wins
      default  : next_state = st_idle;
    endcase
  end

  assign rx_data_ready = (state == st_ready);  // rises with the register load

endmodule

`default_nettype wire

/* design/ps2_keyboard_rx.sv */
// receive only, no parity check; ps2_clk and ps2_data need external pull-ups
`timescale 1ns/100ps
`default_nettype none

module ps2_keyboard_rx #(
  parameter int watchdog_cycles = 3096,  // clk cycles of idle keyboard clock, ~60 us
  parameter bit trap_modifiers  = 1'b1   // hide shift and control codes from the host
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            ps2_clk,
  input  wire logic            ps2_data,
  output      ps2_pkg::code_t  rx_scan_code,
  output      ps2_pkg::ascii_t rx_ascii,
  output      logic            rx_extended,
  output      logic            rx_released,
  output      logic            rx_shift_key_on,
  output      logic            rx_control_key_on,
  output      logic            rx_data_ready,
  input  wire logic            rx_read
);

  logic           frame_done;
  ps2_pkg::code_t scan_code;

  key_event_if ev_link ();  // tracker to output stage

  ps2_frame_receiver #(
    .watchdog_cycles (watchdog_cycles)
  ) rx0 (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .frame_done (frame_done),
    .scan_code  (scan_code)
  );

  ps2_code_tracker #(
    .trap_modifiers (trap_modifiers)
  ) trk0 (
    .clk        (clk),
    .reset      (reset),
    .frame_done (frame_done),
    .scan_code  (scan_code),
    .ev         (ev_link.source)
  );

  ps2_rx_output out0 (
    .clk           (clk),
    .reset         (reset),
    .ev            (ev_link.sink),
    .rx_read       (rx_read),
    .rx_scan_code  (rx_scan_code),
    .rx_ascii      (rx_ascii),
    .rx_extended   (rx_extended),
    .rx_released   (rx_released),
    .rx_data_ready (rx_data_ready)
  );

  // modifier levels are live, not tied to the ready flag
  assign rx_shift_key_on   = ev_link.shift_on;
  assign rx_control_key_on = ev_link.control_on;

endmodule

`default_nettype wire

/* tb/tb_ps2_keyboard_rx.sv */
// needs tb/ps2_golden.txt relative to the run directory; keyboard model sends odd parity frames
`timescale 1ns/100ps
`default_nettype none

module tb_ps2_keyboard_rx;

  localparam int watchdog_cycles = 64;
  localparam int max_records     = 128;
  localparam int max_half        = 12;  // longest keyboard clock half period in clk cycles
  localparam int clk_period_ns   = 4;

  logic            clk = 1'b0;
  logic            reset;
  logic            ps2_clk;
  logic            ps2_data;
  logic            rx_read;
  ps2_pkg::code_t  rx_scan_code;
  ps2_pkg::ascii_t rx_ascii;
  logic            rx_extended;
  logic            rx_released;
  logic            rx_shift_key_on;
  logic            rx_control_key_on;
  logic            rx_data_ready;

  logic [7:0] rec_tag [max_records];      // record letter
  logic [7:0] rec_arg [max_records][6];   // up to six hex fields
  int         rec_count      = 0;
  logic       records_loaded = 1'b0;

  always #(clk_period_ns / 2) clk = ~clk;

  ps2_keyboard_rx #(
    .watchdog_cycles (watchdog_cycles),
    .trap_modifiers  (1'b1)
  ) dut0 (
    .clk (clk), .reset (reset), .ps2_clk (ps2_clk), .ps2_data (ps2_data),
    .rx_scan_code (rx_scan_code), .rx_ascii (rx_ascii),
    .rx_extended (rx_extended), .rx_released (rx_released),
    .rx_shift_key_on (rx_shift_key_on), .rx_control_key_on (rx_control_key_on),
    .rx_data_ready (rx_data_ready), .rx_read (rx_read)
  );

  // ----------------------------------------------------------------------
  // reporting and compare tasks
  // ----------------------------------------------------------------------

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_problem(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_code(input ps2_pkg::code_t got, input ps2_pkg::code_t expected,
                            input string what);
    if (got !== expected)
    begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
      abort_run();
    end
  endtask

  task automatic check_ascii(input ps2_pkg::ascii_t got, input ps2_pkg::ascii_t expected,
                             input string what);
    if (got !== expected)
    begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic expected, input string what);
    if (got !== expected)
    begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, expected);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // keyboard line model
  // ----------------------------------------------------------------------

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // start 0, data lsb first, odd parity, stop 1
  function automatic logic [10:0] make_frame(input ps2_pkg::code_t code);
    return {1'b1, ~^code, code, 1'b0};
  endfunction

  task automatic send_bits(input logic [10:0] frame, input int nbits);
    int half;
    half = 8 + int'($urandom % 5);       // 8 .. 12 clk per half period
    @(negedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      ps2_data = frame[i];               // change data while the clock is high
      wait_cycles(half);
      ps2_clk = 1'b0;                    // receiver samples on this edge
      wait_cycles(half);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    wait_cycles(2 * half);               // idle gap between frames
  endtask

  task automatic send_partial(input int nbits);
    send_bits(make_frame(8'hA5), nbits);
    wait_cycles(2 * watchdog_cycles + 16);  // long enough for the idle timeout
  endtask

  // ----------------------------------------------------------------------
  // golden records
  // ----------------------------------------------------------------------

  task automatic load_golden();
    int         fd;
    string      line;
    logic [7:0] tag;
    int         a [6];
    fd = $fopen("tb/ps2_golden.txt", "r");
    if (fd == 0)
      report_problem("cannot open tb/ps2_golden.txt");
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        if (line.len() > 0 && line[0] != "#" && line[0] != "\n" && rec_count < max_records)
        begin
          foreach (a[k]) a[k] = 0;
          void'($sscanf(line, "%c %h %h %h %h %h %h", tag, a[0], a[1], a[2], a[3], a[4], a[5]));
          rec_tag[rec_count] = tag;
          foreach (a[k]) rec_arg[rec_count][k] = 8'(a[k]);
          rec_count++;
        end
      end
      $fclose(fd);
      records_loaded = 1'b1;
    end
  endtask

  task automatic expect_event(input int idx);
    int waited;
    waited = 0;
    while (!rx_data_ready && waited < 50 * max_half)
    begin
      @(negedge clk);
      waited++;
    end
    if (!rx_data_ready)
      report_problem($sformatf("ready never rose for scan code %h", rec_arg[idx][0]));
    else
    begin
      check_code(rx_scan_code, rec_arg[idx][0], "rx_scan_code");
      check_ascii(rx_ascii, rec_arg[idx][1], "rx_ascii");
      check_flag(rx_extended, rec_arg[idx][2][0], "rx_extended");
      check_flag(rx_released, rec_arg[idx][3][0], "rx_released");
      check_flag(rx_shift_key_on, rec_arg[idx][4][0], "rx_shift_key_on");
      check_flag(rx_control_key_on, rec_arg[idx][5][0], "rx_control_key_on");
      repeat (5)
      begin
        @(negedge clk);
        check_flag(rx_data_ready, 1'b1, "rx_data_ready before read");  // held until read
      end
      rx_read = 1'b1;
      @(negedge clk);
      rx_read = 1'b0;
      @(negedge clk);
      check_flag(rx_data_ready, 1'b0, "rx_data_ready after read");
    end
  endtask

  task automatic expect_levels(input int idx);
    wait_cycles(2);
    check_flag(rx_shift_key_on, rec_arg[idx][0][0], "rx_shift_key_on");
    check_flag(rx_control_key_on, rec_arg[idx][1][0], "rx_control_key_on");
  endtask

  task automatic expect_quiet();
    repeat (4 * max_half)
    begin
      @(negedge clk);
      check_flag(rx_data_ready, 1'b0, "rx_data_ready with no event");
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial
  begin
    void'($urandom(32'h0403036b));
    reset    = 1'b1;
    ps2_clk  = 1'b1;                     // idle keyboard lines are high
    ps2_data = 1'b1;
    rx_read  = 1'b0;
    load_golden();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_code(rx_scan_code, 8'h00, "rx_scan_code after reset");
    check_ascii(rx_ascii, 8'h00, "rx_ascii after reset");
    check_flag(rx_extended, 1'b0, "rx_extended after reset");
    check_flag(rx_released, 1'b0, "rx_released after reset");
    check_flag(rx_shift_key_on, 1'b0, "rx_shift_key_on after reset");
    check_flag(rx_control_key_on, 1'b0, "rx_control_key_on after reset");
    check_flag(rx_data_ready, 1'b0, "rx_data_ready after reset");
    for (int i = 0; i < rec_count; i++)
    begin
      case (rec_tag[i])
        "S"     : send_bits(make_frame(rec_arg[i][0]), ps2_pkg::frame_bits);
        "P"     : send_partial(int'(rec_arg[i][0]));
        "E"     : expect_event(i);
        "M"     : expect_levels(i);
        "N"     : expect_quiet();
        default : report_problem($sformatf("unknown golden record letter %c", rec_tag[i]));
      endcase
    end
    $display("RESULT: PASS");
    $finish;
  end

  // run limit of 40 keyboard bit times per record
  initial
  begin : run_watchdog
    longint limit_ns;
    wait (records_loaded);
    limit_ns = longint'(rec_count) * 40 * 2 * max_half * clk_period_ns;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* list.f */
design/ps2_pkg.sv
design/key_event_if.sv
design/ps2_frame_receiver.sv
design/ps2_code_tracker.sv
design/scan_ascii_map.sv
design/ps2_rx_output.sv
design/ps2_keyboard_rx.sv
tb/tb_ps2_keyboard_rx.sv

/* Bender.yml */
package:
  name: ps2_keyboard_rx

sources:
  # package and interface ahead of the modules that use them
  - files:
      - design/ps2_pkg.sv
      - design/key_event_if.sv
      - design/ps2_frame_receiver.sv
      - design/ps2_code_tracker.sv
      - design/scan_ascii_map.sv
      - design/ps2_rx_output.sv
      - design/ps2_keyboard_rx.sv

  - target: simulation
    files:
      - tb/tb_ps2_keyboard_rx.sv

/* tb/ps2_golden.txt */
# S code | P nbits | E code ascii extended released shift control | M shift control | N
# fields in hex; E, M and N check the result of the sends just before them
S 1C
E 1C 61 0 0 0 0
S 32
E 32 62 0 0 0 0
S 16
E 16 31 0 0 0 0
S 45
E 45 30 0 0 0 0
S 12
N
M 1 0
S 1C
E 1C 41 0 0 1 0
S 1E
E 1E 40 0 0 1 0
S F0
S 1C
E 1C 41 0 1 1 0
S F0
S 12
N
M 0 0
S 59
M 1 0
S 46
E 46 28 0 0 1 0
S F0
S 59
M 0 0
S F0
S 32
E 32 62 0 1 0 0
S E0
S 5A
E 5A 0D 1 0 0 0
S E0
S 1C
E 1C 00 1 0 0 0
S 14
N
M 0 1
S 1C
E 1C 01 0 0 0 1
S F0
S 14
M 0 0
P 5
N
S 33
E 33 68 0 0 0 0
P 9
S 16
E 16 31 0 0 0 0
